// File: all.f
cachePkg.sv
cacheArray.sv
cacheWay.sv
cacheCtrl.sv
dcache.sv
tbMemModel.sv
dcacheTb.sv

// File: dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

  import cachePkg::*;

  localparam int PERIOD = 100;
  localparam int TIMEOUT = 400;
  localparam int NUM_RANDOM = 300;
  localparam logic [15:0] SEED = 16'd28;
  localparam int NUM_WORDS = 1 << (PA_BITS - 2);

  logic clk;
  logic rst;
  rwT rw;
  logic flush;
  adrT adr;
  wordT writeData;
  wordT readData;
  logic done;
  logic fetchLine;
  logic writeLine;
  logic busAck;
  adrT busAdr;
  lineT busWriteData;
  lineT memLineData;
  logic miss;
  logic access;
  logic [1:0] delaySel;

  // cpu view of memory and the expected state of each line
  wordT shadow [NUM_WORDS];
  tagT tagRef [NUM_LINES];
  logic [NUM_LINES-1:0] validRef;
  logic [NUM_LINES-1:0] dirtyRef;
  logic [15:0] lfsr;

  // expected and seen results of the request in flight
  wordT expRead;
  logic expMiss;
  logic expFetch;
  adrT expFetchAdr;
  adrT expWb [$];
  adrT seenWb [$];
  int accessCnt;
  int missCnt;
  int fetchCnt;
  logic reqRead;
  logic reqFlush;
  time startTime;
  logic prevBusReq;
  logic hung;
  int reqCount;
  int valueErrs;
  int otherErrs;

  dcache UUT (
    .clk, .rst, .rw, .flush, .adr, .writeData, .readData, .done,
    .fetchLine, .writeLine, .busAck, .busAdr, .busWriteData, .memLineData,
    .miss, .access
  );

  tbMemModel memory (
    .clk, .rst, .fetchLine, .writeLine, .busAdr, .busWriteData,
    .delaySel, .memLineData, .busAck
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random numbers and reference
  //////////////////////////////////////////////////

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // direct-mapped write-back rules, write-allocate on a miss
  function automatic void predict(input logic doFlush, input logic doWrite,
                                  input adrT a, input wordT d);
    tagT t;
    indexT ix;
    t = a[PA_BITS-1 -: TAG_LEN];
    ix = a[OFFSET_LEN +: INDEX_LEN];
    expWb.delete();
    expMiss = 1'b0;
    expFetch = 1'b0;
    expFetchAdr = {t, ix, {OFFSET_LEN{1'b0}}};
    if (doFlush) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        if (validRef[i] && dirtyRef[i]) begin
          expWb.push_back({tagRef[i], indexT'(i), {OFFSET_LEN{1'b0}}});
        end
        dirtyRef[i] = 1'b0;
      end
    end else begin
      if (!(validRef[ix] && tagRef[ix] == t)) begin
        expMiss = 1'b1;
        expFetch = 1'b1;
        // dirty victim goes out before the fill
        if (validRef[ix] && dirtyRef[ix]) begin
          expWb.push_back({tagRef[ix], ix, {OFFSET_LEN{1'b0}}});
        end
        tagRef[ix] = t;
        validRef[ix] = 1'b1;
        dirtyRef[ix] = 1'b0;
      end
      if (doWrite) begin
        shadow[a[PA_BITS-1:2]] = d;
        dirtyRef[ix] = 1'b1;
      end
      expRead = shadow[a[PA_BITS-1:2]];
    end
  endfunction

  //////////////////////////////////////////////////
  // monitor and compare
  //////////////////////////////////////////////////

  task automatic noteBusStart();
    lineT expLine;
    if (writeLine) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        expLine[w] = shadow[{busAdr[PA_BITS-1:OFFSET_LEN], 2'(w)}];
      end
      assert (busWriteData === expLine) else begin
        $display("Fail busWriteData: got %h expected %h", busWriteData, expLine);
        valueErrs++;
      end
      assert (fetchCnt == 0) else begin
        $display("write-back started after the line fetch");
        otherErrs++;
      end
      seenWb.push_back(busAdr);
    end else begin
      assert (busAdr === expFetchAdr) else begin
        $display("Fail busAdr: got %h expected %h", busAdr, expFetchAdr);
        valueErrs++;
      end
      fetchCnt++;
    end
  endtask

  task automatic compareRequest();
    time cycles;
    cycles = ($time - startTime) / PERIOD;
    if (reqRead) begin
      assert (readData === expRead) else begin
        $display("Fail readData: got %h expected %h", readData, expRead);
        valueErrs++;
      end
    end
    assert (accessCnt == int'(!reqFlush)) else begin
      $display("Fail access: got %h expected %h", accessCnt, !reqFlush);
      valueErrs++;
    end
    assert (missCnt == int'(expMiss)) else begin
      $display("Fail miss: got %h expected %h", missCnt, expMiss);
      valueErrs++;
    end
    assert (fetchCnt == int'(expFetch)) else begin
      $display("Fail fetchLine: got %h expected %h", fetchCnt, expFetch);
      valueErrs++;
    end
    assert (seenWb.size() == expWb.size()) else begin
      $display("Fail writeLine: got %h expected %h", seenWb.size(), expWb.size());
      valueErrs++;
    end
    for (int i = 0; i < seenWb.size() && i < expWb.size(); i++) begin
      assert (seenWb[i] === expWb[i]) else begin
        $display("Fail busAdr: got %h expected %h", seenWb[i], expWb[i]);
        valueErrs++;
      end
    end
    // a hit answers in the cycle after the request is sampled
    if (!expMiss && !reqFlush) begin
      assert (cycles == 1) else begin
        $display("hit took %0d cycles instead of one", cycles);
        otherErrs++;
      end
    end
    accessCnt = 0;
    missCnt = 0;
    fetchCnt = 0;
    seenWb.delete();
    reqCount++;
  endtask

  // mid-cycle sampling, outputs are settled here
  always @(negedge clk) begin
    if (!rst) begin
      if (access) begin
        accessCnt++;
      end
      if (miss) begin
        missCnt++;
      end
      // busAck still holds last cycle's value, so a high one ended a transfer
      if ((writeLine || fetchLine) && (!prevBusReq || busAck)) begin
        noteBusStart();
      end
      if (done) begin
        compareRequest();
      end
      prevBusReq = writeLine || fetchLine;
    end
  end

  // new delay for the memory model every cycle
  always @(posedge clk) begin
    delaySel <= 2'(randBits(2));
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic waitDone();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < TIMEOUT && !seen; i++) begin
      @(negedge clk);
      seen = done;
    end
    if (!seen) begin
      $display("timeout: no done within %0d cycles of the request", TIMEOUT);
      otherErrs++;
      hung = 1'b1;
    end
  endtask

  // held until done, the next one goes out a cycle later
  task automatic runRequest(input logic doFlush, input logic doWrite,
                            input adrT a, input wordT d);
    if (!hung) begin
      @(negedge clk);
      predict(doFlush, doWrite, a, d);
      reqFlush = doFlush;
      reqRead = !doFlush && !doWrite;
      startTime = $time;
      flush = doFlush;
      rw = doFlush ? RW_IDLE : (doWrite ? RW_WRITE : RW_READ);
      adr = a;
      writeData = d;
      waitDone();
    end
  endtask

  // two tags over all indexes, so lines keep conflicting
  task automatic randomRequest();
    adrT a;
    logic wr;
    wordT d;
    a = {(randBits(1) != 0) ? 8'hA5 : 8'h3C, 4'(randBits(4)), 2'(randBits(2)), 2'b00};
    wr = randBits(1) != 0;
    d = wr ? randBits(32) : '0;
    runRequest(1'b0, wr, a, d);
  endtask

  task automatic checkMemory();
    if (!hung) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        assert (memory.mem[i >> 2][i % 4] === shadow[i]) else begin
          $display("Fail mem[%h]: got %h expected %h", i << 2,
                   memory.mem[i >> 2][i % 4], shadow[i]);
          valueErrs++;
        end
      end
    end
  endtask

  task automatic finishRun();
    $display("requests %0d, value errors %0d, other errors %0d",
             reqCount, valueErrs, otherErrs);
    if (valueErrs + otherErrs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  initial begin
    rst = 1'b1;
    rw = RW_IDLE;
    flush = 1'b0;
    adr = '0;
    writeData = '0;
    lfsr = SEED;
    validRef = '0;
    dirtyRef = '0;
    prevBusReq = 1'b0;
    hung = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      shadow[i] = memory.mem[i >> 2][i % 4];
    end
    // cold read, then read and write hits on the same line
    runRequest(1'b0, 1'b0, {8'h3C, 4'h3, 4'h4}, '0);
    runRequest(1'b0, 1'b0, {8'h3C, 4'h3, 4'h8}, '0);
    runRequest(1'b0, 1'b1, {8'h3C, 4'h3, 4'h4}, 32'h1234_5678);
    runRequest(1'b0, 1'b0, {8'h3C, 4'h3, 4'h4}, '0);
    // dirty victim, then a clean one
    runRequest(1'b0, 1'b0, {8'hA5, 4'h3, 4'h0}, '0);
    runRequest(1'b0, 1'b0, {8'h3C, 4'h3, 4'h4}, '0);
    // flush two dirty lines, the second flush finds nothing
    runRequest(1'b0, 1'b1, {8'hA5, 4'h5, 4'hC}, 32'h0BAD_F00D);
    runRequest(1'b0, 1'b1, {8'h3C, 4'h9, 4'h0}, 32'h5555_AAAA);
    runRequest(1'b1, 1'b0, '0, '0);
    checkMemory();
    runRequest(1'b1, 1'b0, '0, '0);
    repeat (NUM_RANDOM) randomRequest();
    runRequest(1'b1, 1'b0, '0, '0);
    checkMemory();
    finishRun();
  end

endmodule

// File: tbMemModel.sv
`timescale 1ns/1ps

// bus memory for the testbench
// answers line fetches and write-backs after a short variable delay
module tbMemModel (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetchLine,
  input  logic           writeLine,
  input  cachePkg::adrT  busAdr,
  input  cachePkg::lineT busWriteData,
  input  logic [1:0]     delaySel,
  output cachePkg::lineT memLineData,
  output logic           busAck
);

  import cachePkg::*;

  localparam int MEM_LINES = 1 << (PA_BITS - OFFSET_LEN);

  lineT mem [MEM_LINES];
  logic busy;
  logic [2:0] waitCnt;
  logic [PA_BITS-OFFSET_LEN-1:0] lineAdr;

  assign lineAdr = busAdr[PA_BITS-1:OFFSET_LEN];

  initial begin
    adrT a;
    busAck = 1'b0;
    memLineData = '0;
    // each word mixes its own byte address into both halves
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        a = adrT'(l * 16 + w * 4);
        mem[l][w] = {a ^ 16'hC3A5, a};
      end
    end
  end

  // everything moves on the falling edge, away from the cache's sampling edge
  always @(negedge clk) begin
    if (rst) begin
      busAck <= 1'b0;
      busy <= 1'b0;
      waitCnt <= '0;
    end else if (busAck) begin
      // single-cycle ack, a new request is picked up after it
      busAck <= 1'b0;
    end else if (busy) begin
      if (waitCnt == 3'd1) begin
        busy <= 1'b0;
        busAck <= 1'b1;
        if (writeLine) begin
          mem[lineAdr] <= busWriteData;
        end else begin
          memLineData <= mem[lineAdr];
        end
      end else begin
        waitCnt <= waitCnt - 3'd1;
      end
    end else if (fetchLine || writeLine) begin
      // 1 to 4 cycles until the ack
      busy <= 1'b1;
      waitCnt <= {1'b0, delaySel} + 3'd1;
    end
  end

endmodule

// File: dcache.sv
`timescale 1ns/1ps

// direct-mapped write-back L1 data cache
module dcache (
  input  logic           clk,
  input  logic           rst,
  // cpu side
  input  cachePkg::rwT   rw,
  input  logic           flush,
  input  cachePkg::adrT  adr,
  input  cachePkg::wordT writeData,
  output cachePkg::wordT readData,
  output logic           done,
  // bus side
  output logic           fetchLine,
  output logic           writeLine,
  input  logic           busAck,
  output cachePkg::adrT  busAdr,
  output cachePkg::lineT busWriteData,
  input  cachePkg::lineT memLineData,
  // performance counters
  output logic           miss,
  output logic           access
);

  import cachePkg::*;

  tagT reqTag;
  indexT reqIndex;
  logic [LOG_WPL-1:0] wordSel;
  indexT arrayIndex;
  lineT wayLine;
  lineT readLine;
  tagT victimTag;
  indexT flushIndex;
  logic hit;
  logic victimDirty;
  logic setValid;
  logic setDirty;
  logic clearDirty;
  logic wordWriteEn;
  logic lineWriteEn;
  logic selFlush;
  logic selFetch;

  //////////////////////////////////////////////////
  // address split and array index
  //////////////////////////////////////////////////

  assign reqTag = adr[PA_BITS-1 -: TAG_LEN];
  assign reqIndex = adr[OFFSET_LEN +: INDEX_LEN];
  // word select sits just above the byte offset
  assign wordSel = adr[OFFSET_LEN-1 -: LOG_WPL];

  // flush walks the lines, everything else uses the request index
  assign arrayIndex = selFlush ? flushIndex : reqIndex;

  // fills take the bus line, word writes the replicated cpu word
  assign wayLine = selFetch ? memLineData : {WORDS_PER_LINE{writeData}};

  cacheWay way (
    .clk,
    .rst,
    .index(arrayIndex),
    .tag(reqTag),
    .wordSel,
    .wordWriteEn,
    .lineWriteEn,
    .setValid,
    .setDirty,
    .clearDirty,
    .writeLine(wayLine),
    .readLine,
    .hit,
    .victimDirty,
    .victimTag
  );

  cacheCtrl ctrl (
    .clk,
    .rst,
    .rw,
    .flush,
    .hit,
    .victimDirty,
    .busAck,
    .done,
    .fetchLine,
    .writeLine,
    .wordWriteEn,
    .lineWriteEn,
    .setValid,
    .setDirty,
    .clearDirty,
    .selFlush,
    .selFetch,
    .flushIndex,
    .miss,
    .access
  );

  //////////////////////////////////////////////////
  // result select and bus address
  //////////////////////////////////////////////////

  // addressed word of the line on the array output
  assign readData = readLine[wordSel];

  // fetch uses the request tag, write-back the stored victim tag
  // the index is whatever the array is reading, request or flush
  assign busAdr = {selFetch ? reqTag : victimTag, arrayIndex, {OFFSET_LEN{1'b0}}};

  // victim line straight from the data array
  assign busWriteData = readLine;

endmodule

// File: cacheCtrl.sv
`timescale 1ns/1ps

// request decode and sequencing of lookup, eviction, fill and flush
module cacheCtrl (
  input  logic            clk,
  input  logic            rst,
  input  cachePkg::rwT    rw,
  input  logic            flush,
  input  logic            hit,
  input  logic            victimDirty,
  input  logic            busAck,
  output logic            done,
  output logic            fetchLine,
  output logic            writeLine,
  output logic            wordWriteEn,
  output logic            lineWriteEn,
  output logic            setValid,
  output logic            setDirty,
  output logic            clearDirty,
  output logic            selFlush,
  output logic            selFetch,
  output cachePkg::indexT flushIndex,
  output logic            miss,
  output logic            access
);

  import cachePkg::*;

  typedef enum logic [2:0] {
    idle,
    lookup,
    evict,
    fetch,
    flushCheck,
    flushWrite
  } stateT;

  stateT state;
  stateT nextState;
  indexT flushCnt;
  logic lastIndex;
  logic advance;
  logic relookup;
  logic isRead;
  logic isWrite;

  // request decode
  assign isRead = (rw == RW_READ);
  assign isWrite = (rw == RW_WRITE);
  assign lastIndex = (flushCnt == indexT'(NUM_LINES - 1));

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    advance = 1'b0;
    case (state)
      idle: begin
        if (flush) begin
          nextState = flushCheck;
        end else if (isRead || isWrite) begin
          nextState = lookup;
        end
      end
      lookup: begin
        // hit ends the request, miss evicts first if needed
        if (hit) begin
          nextState = idle;
        end else if (victimDirty) begin
          nextState = evict;
        end else begin
          nextState = fetch;
        end
      end
      evict: begin
        if (busAck) begin
          nextState = fetch;
        end
      end
      fetch: begin
        // look up again once the new line is in place
        if (busAck) begin
          nextState = lookup;
        end
      end
      flushCheck: begin
        // a written-back line comes back here with dirty clear
        if (victimDirty) begin
          nextState = flushWrite;
        end else if (lastIndex) begin
          nextState = idle;
        end else begin
          advance = 1'b1;
        end
      end
      flushWrite: begin
        if (busAck) begin
          nextState = flushCheck;
        end
      end
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  //////////////////////////////////////////////////
  // flush index and lookup bookkeeping
  //////////////////////////////////////////////////

  // back at index 0 before idle so a new flush reads line 0 first
  always_ff @(posedge clk) begin
    if (rst || nextState == idle) begin
      flushCnt <= '0;
    end else if (advance) begin
      flushCnt <= flushCnt + 1'b1;
    end
  end

  // present the next index early so the array reads it on this edge
  assign flushIndex = advance ? indexT'(flushCnt + 1'b1) : flushCnt;

  // marks the lookup that follows a fill
  always_ff @(posedge clk) begin
    if (rst || state == idle) begin
      relookup <= 1'b0;
    end else if (state == fetch && busAck) begin
      relookup <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign done = (state == lookup && hit) ||
                (state == flushCheck && !victimDirty && lastIndex);
  assign fetchLine = (state == fetch);
  assign writeLine = (state == evict) || (state == flushWrite);

  // write hit updates the word and marks the line dirty
  assign wordWriteEn = (state == lookup) && hit && isWrite;
  assign setDirty = wordWriteEn;

  // fill stores the bus line as a clean valid line
  assign lineWriteEn = (state == fetch) && busAck;
  assign setValid = lineWriteEn;
  assign clearDirty = lineWriteEn || (state == flushWrite && busAck);

  assign selFetch = (state == fetch);
  assign selFlush = (state == idle && flush) ||
                    (state == flushCheck) || (state == flushWrite);

  // performance pulses on the first lookup only
  assign access = (state == lookup) && !relookup;
  assign miss = access && !hit;

  busExclusive: assert property (
    @(posedge clk) disable iff (rst) !(fetchLine && writeLine)
  ) else $error("cacheCtrl: fetchLine and writeLine both high");

endmodule

// File: cacheWay.sv
`timescale 1ns/1ps

// one direct-mapped way: tag store, data store and line state bits
module cacheWay (
  input  logic                          clk,
  input  logic                          rst,
  input  cachePkg::indexT               index,
  input  cachePkg::tagT                 tag,
  input  logic [cachePkg::LOG_WPL-1:0]  wordSel,
  input  logic                          wordWriteEn,
  input  logic                          lineWriteEn,
  input  logic                          setValid,
  input  logic                          setDirty,
  input  logic                          clearDirty,
  input  cachePkg::lineT                writeLine,
  output cachePkg::lineT                readLine,
  output logic                          hit,
  output logic                          victimDirty,
  output cachePkg::tagT                 victimTag
);

  import cachePkg::*;

  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] dirty;
  indexT indexQ;
  tagT storedTag;
  lineT mergedLine;
  lineT arrayLine;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // tag only changes when a whole line comes in from the bus
  cacheArray #(.T(tagT), .DEPTH(NUM_LINES)) tagArray (
    .clk,
    .index,
    .writeEn(lineWriteEn),
    .writeData(tag),
    .readData(storedTag)
  );

  // word write: splice the new word into the line read last cycle
  always_comb begin
    mergedLine = readLine;
    mergedLine[wordSel] = writeLine[wordSel];
  end

  assign arrayLine = wordWriteEn ? mergedLine : writeLine;

  cacheArray #(.T(lineT), .DEPTH(NUM_LINES)) lineArray (
    .clk,
    .index,
    .writeEn(wordWriteEn | lineWriteEn),
    .writeData(arrayLine),
    .readData(readLine)
  );

  //////////////////////////////////////////////////
  // line state and lookup
  //////////////////////////////////////////////////

  // index of the line now on the array outputs
  always_ff @(posedge clk) begin
    indexQ <= index;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (setValid) begin
        valid[index] <= 1'b1;
      end
      // set and clear never come together
      if (setDirty) begin
        dirty[index] <= 1'b1;
      end else if (clearDirty) begin
        dirty[index] <= 1'b0;
      end
    end
  end

  assign hit = valid[indexQ] && (storedTag == tag);
  // only a valid line can need a write-back
  assign victimDirty = valid[indexQ] && dirty[indexQ];
  assign victimTag = storedTag;

  oneWritePort: assert property (
    @(posedge clk) disable iff (rst) !(wordWriteEn && lineWriteEn)
  ) else $error("cacheWay: word and line write in the same cycle");

  // a fill must make the very next lookup hit
  fillThenHit: assert property (
    @(posedge clk) disable iff (rst) lineWriteEn |=> hit
  ) else $error("cacheWay: no hit in the cycle after a line fill");

endmodule

// File: cacheArray.sv
`timescale 1ns/1ps

// storage for one payload per line, used for both tags and data lines
module cacheArray #(
  parameter type T = cachePkg::lineT,
  parameter int DEPTH = cachePkg::NUM_LINES
) (
  input  logic            clk,
  input  cachePkg::indexT index,
  input  logic            writeEn,
  input  T                writeData,
  output T                readData
);

  // one entry per cache line
  T mem [DEPTH];

  // registered read, one cycle after the index
  // a write forwards its data to the read port so the
  // next lookup on the same index sees the new contents
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[index] <= writeData;
      readData <= writeData;
    end else begin
      readData <= mem[index];
    end
  end

  // an unknown index on a write would corrupt an unknown entry
  writeIndexKnown: assert property (
    @(posedge clk) writeEn |-> !$isunknown(index)
  ) else $error("cacheArray: write with unknown index %h", index);

endmodule

// File: cachePkg.sv
package cachePkg;

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  // one data word and the physical address space
  localparam int XLEN = 32;
  localparam int PA_BITS = 16;

  // direct-mapped, 16 lines of four words
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_LINES = 16;

  // address split: tag | index | word | byte
  localparam int OFFSET_LEN = $clog2(WORDS_PER_LINE * XLEN / 8);
  localparam int INDEX_LEN = $clog2(NUM_LINES);
  localparam int TAG_LEN = PA_BITS - OFFSET_LEN - INDEX_LEN;
  localparam int LOG_WPL = $clog2(WORDS_PER_LINE);

  //////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0] wordT;
  // word 0 sits in the low bits of the line
  typedef wordT [WORDS_PER_LINE-1:0] lineT;
  typedef logic [TAG_LEN-1:0] tagT;
  typedef logic [INDEX_LEN-1:0] indexT;
  typedef logic [PA_BITS-1:0] adrT;

  // cpu request code, 11 is unused
  typedef logic [1:0] rwT;
  localparam rwT RW_IDLE = 2'b00;
  localparam rwT RW_WRITE = 2'b01;
  localparam rwT RW_READ = 2'b10;

endpackage
